//--- common/ex_params.svh
//////////////////////////////////////////////////
// execute stage parameters
// data width, alu control and operation kind codes
//////////////////////////////////////////////////

`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// data width, 32 for rv32 and 64 for rv64
`define EX_XLEN 32

// alu control for subtract, branches compare with this
`define EX_ALU_SUB 5'b01000

// operation kind
`define EX_KIND_ALU    2'd0
`define EX_KIND_BRANCH 2'd1
`define EX_KIND_JAL    2'd2
`define EX_KIND_JALR   2'd3

// branch conditions as in funct3
`define EX_F3_BEQ  3'b000
`define EX_F3_BNE  3'b001
`define EX_F3_BLT  3'b100
`define EX_F3_BGE  3'b101
`define EX_F3_BLTU 3'b110
`define EX_F3_BGEU 3'b111

`endif

//--- common/ex_pkg.sv
//////////////////////////////////////////////////
// execute stage types
// data word, alu control, flags, request and response
//////////////////////////////////////////////////

`include "ex_params.svh"

package ex_pkg;

  // one data word of the configured width
  typedef logic [`EX_XLEN-1:0] xlen_t;

  // alu control
  // bit 4 w form, bit 3 sub / arith shift / pass b, bits 2:0 operation
  typedef logic [4:0] alu_ctrl_t;

  // condition flags ordered zero, signed lt, unsigned lt
  typedef logic [2:0] alu_flags_t;

  // operation kind, see EX_KIND_* codes
  typedef logic [1:0] ex_kind_t;

  // branch condition straight from the instruction
  typedef logic [2:0] funct3_t;

  //////////////////////////////////////////////////
  // handshake payloads
  //////////////////////////////////////////////////

  // issued operation, b already muxed between rs2 and imm
  typedef struct packed {
    ex_kind_t  kind;
    funct3_t   funct3;
    alu_ctrl_t alu_ctrl;
    xlen_t     pc;
    xlen_t     a;
    xlen_t     b;
    xlen_t     imm;
  } ex_req_t;

  // writeback value and redirect info
  typedef struct packed {
    xlen_t pc;
    xlen_t result;
    logic  taken;
    xlen_t target;
  } ex_resp_t;

endpackage

//--- alu/shifter.sv
//////////////////////////////////////////////////
// barrel shifter for sll, srl and sra
// rv64 w forms work on the low word and sign-extend
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_params.svh"

module shifter
  import ex_pkg::*;
#(
  parameter int WIDTH = `EX_XLEN
) (
  input  xlen_t      a,
  input  logic [5:0] shamt,
  input  logic       right,
  input  logic       arith,
  input  logic       w64,
  output xlen_t      y
);

  logic [WIDTH-1:0] src;
  logic [WIDTH-1:0] shifted;
  logic [5:0]       amt;

  // operand and amount prep
  generate
    if (WIDTH == 64) begin : g_rv64
      always_comb begin
        if (w64) begin
          // low word only, upper bits filled so right shifts pull in the right bit
          src = (right & arith) ? {{(WIDTH-32){a[31]}}, a[31:0]}
                                : {{(WIDTH-32){1'b0}}, a[31:0]};
          amt = {1'b0, shamt[4:0]};
        end else begin
          src = a;
          amt = shamt;
        end
      end
      // w result is the low word sign-extended
      assign y = w64 ? {{(WIDTH-32){shifted[31]}}, shifted[31:0]} : shifted;
    end else begin : g_rv32
      // rv32 has no w form, 5-bit amount
      assign src = a;
      assign amt = {1'b0, shamt[4:0]};
      assign y   = shifted;
    end
  endgenerate

  // the shift itself
  always_comb begin
    if (!right)
      shifted = src << amt;
    else if (arith)
      shifted = $unsigned($signed(src) >>> amt);
    else
      shifted = src >> amt;
  end

endmodule

//--- alu/alu.sv
//////////////////////////////////////////////////
// integer alu
// add/sub, logic ops, slt/sltu, shifts and flags
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_params.svh"

module alu
  import ex_pkg::*;
#(
  parameter int WIDTH = `EX_XLEN
) (
  input  xlen_t      a,
  input  xlen_t      b,
  input  alu_ctrl_t  alu_ctrl,
  output xlen_t      result,
  output alu_flags_t flags
);

  logic [WIDTH-1:0] cond_inv_b;
  logic [WIDTH-1:0] pre_sum;
  logic [WIDTH-1:0] sum;
  logic [WIDTH-1:0] shift;
  logic [WIDTH-1:0] slt;
  logic [WIDTH-1:0] sltu;
  logic [WIDTH-1:0] b_or;
  logic             carry;
  logic             zero;
  logic             neg;
  logic             overflow;
  logic             lt;
  logic             ltu;
  logic             right;
  logic             arith;
  logic             w64;

  //////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////

  // subtract as a + ~b + 1
  assign cond_inv_b = alu_ctrl[3] ? ~b : b;
  assign {carry, pre_sum} = a + cond_inv_b + {{(WIDTH-1){1'b0}}, alu_ctrl[3]};

  // addw/subw/addiw keep the low word, sign-extended
  generate
    if (WIDTH == 64) begin : g_sum_w
      assign sum = w64 ? {{(WIDTH-32){pre_sum[31]}}, pre_sum[31:0]} : pre_sum;
    end else begin : g_sum
      assign sum = pre_sum;
    end
  endgenerate

  //////////////////////////////////////////////////
  // shifts and logic
  //////////////////////////////////////////////////

  assign w64   = alu_ctrl[4];
  // bit 3 picks sra over srl
  assign arith = alu_ctrl[3];
  // 101 is srl/sra, 001 is sll
  assign right = (alu_ctrl[2:0] == 3'b101);

  shifter #(
    .WIDTH(WIDTH)
  ) shifter_i (
    .a    (a),
    .shamt(b[5:0]),
    .right(right),
    .arith(arith),
    .w64  (w64),
    .y    (shift)
  );

  // or slot doubles as pass b for lui
  assign b_or = alu_ctrl[3] ? b : (a | b);

  //////////////////////////////////////////////////
  // flags from the adder
  //////////////////////////////////////////////////

  assign zero = (sum == '0);
  assign neg  = sum[WIDTH-1];
  // operands of equal sign but sum of the other sign
  assign overflow = (a[WIDTH-1] ~^ cond_inv_b[WIDTH-1]) & (a[WIDTH-1] ^ sum[WIDTH-1]);
  assign lt    = neg ^ overflow;
  // no carry out of a - b means a < b unsigned
  assign ltu   = ~carry;
  assign flags = {zero, lt, ltu};

  assign slt  = {{(WIDTH-1){1'b0}}, lt};
  assign sltu = {{(WIDTH-1){1'b0}}, ltu};

  // result select
  always_comb begin
    case (alu_ctrl[2:0])
      3'b000:  result = sum;      // add, sub
      3'b001:  result = shift;    // sll
      3'b010:  result = slt;
      3'b011:  result = sltu;
      3'b100:  result = a ^ b;
      3'b101:  result = shift;    // srl, sra
      3'b110:  result = b_or;     // or, lui
      default: result = a & b;
    endcase
  end

endmodule

//--- hw/target_gen.sv
//////////////////////////////////////////////////
// link address and branch/jump target adders
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_params.svh"

module target_gen
  import ex_pkg::*;
(
  input  ex_kind_t kind,
  input  xlen_t    pc,
  input  xlen_t    a,
  input  xlen_t    imm,
  output xlen_t    link,
  output xlen_t    target
);

  logic  is_jalr;
  xlen_t base;
  xlen_t raw_target;

  assign is_jalr = (kind == `EX_KIND_JALR);

  // return address for jal/jalr
  assign link = pc + xlen_t'(4);

  // jalr is register relative, everything else pc relative
  assign base       = is_jalr ? a : pc;
  assign raw_target = base + imm;

  // jalr drops bit 0
  // misaligned targets go out as they are
  assign target = is_jalr ? {raw_target[`EX_XLEN-1:1], 1'b0} : raw_target;

endmodule

//--- hw/ex_result.sv
//////////////////////////////////////////////////
// execute result stage
// branch decision, writeback mux and output register
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_params.svh"

module ex_result
  import ex_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  output logic       in_ready,
  input  ex_kind_t   kind,
  input  funct3_t    funct3,
  input  xlen_t      pc,
  input  xlen_t      alu_result,
  input  alu_flags_t flags,
  input  xlen_t      link,
  input  xlen_t      target,
  output ex_resp_t   resp,
  output logic       resp_valid,
  input  logic       resp_ready
);

  logic     flag_zero;
  logic     flag_lt;
  logic     flag_ltu;
  logic     is_jump;
  logic     is_branch;
  logic     cond_met;
  logic     taken;
  ex_resp_t resp_next;

  // flags ordered zero, lt, ltu
  assign flag_zero = flags[2];
  assign flag_lt   = flags[1];
  assign flag_ltu  = flags[0];

  assign is_jump   = (kind == `EX_KIND_JAL) || (kind == `EX_KIND_JALR);
  assign is_branch = (kind == `EX_KIND_BRANCH);

  //////////////////////////////////////////////////
  // branch decision
  //////////////////////////////////////////////////

  always_comb begin
    case (funct3)
      `EX_F3_BEQ:  cond_met = flag_zero;
      `EX_F3_BNE:  cond_met = ~flag_zero;
      `EX_F3_BLT:  cond_met = flag_lt;
      `EX_F3_BGE:  cond_met = ~flag_lt;
      `EX_F3_BLTU: cond_met = flag_ltu;
      `EX_F3_BGEU: cond_met = ~flag_ltu;
      // 010 and 011 are not branches
      default:     cond_met = 1'b0;
    endcase
  end

  // jumps always redirect, plain alu ops never
  assign taken = is_jump | (is_branch & cond_met);

  // response word for the register
  always_comb begin
    resp_next.pc     = pc;
    resp_next.result = is_jump ? link : alu_result;
    resp_next.taken  = taken;
    resp_next.target = target;
  end

  //////////////////////////////////////////////////
  // one-entry output register
  //////////////////////////////////////////////////

  // accept when empty or when the held item leaves this edge
  assign in_ready = ~resp_valid | resp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (in_ready) begin
      resp_valid <= in_valid;
    end
  end

  // payload only loads on a transfer, holds under stall
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      resp <= resp_next;
    end
  end

endmodule

//--- hw/ex_stage.sv
//////////////////////////////////////////////////
// integer execute stage top
// alu and target adders feed the result register
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_params.svh"

module ex_stage
  import ex_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  ex_req_t  req,
  input  logic     req_valid,
  output logic     req_ready,
  output ex_resp_t resp,
  output logic     resp_valid,
  input  logic     resp_ready
);

  xlen_t      alu_result;
  alu_flags_t flags;
  xlen_t      link;
  xlen_t      target;

  // arithmetic path, branches arrive here as subtract
  alu #(
    .WIDTH(`EX_XLEN)
  ) alu_i (
    .a       (req.a),
    .b       (req.b),
    .alu_ctrl(req.alu_ctrl),
    .result  (alu_result),
    .flags   (flags)
  );

  // link and redirect target, in parallel with the alu
  target_gen target_gen_i (
    .kind  (req.kind),
    .pc    (req.pc),
    .a     (req.a),
    .imm   (req.imm),
    .link  (link),
    .target(target)
  );

  // decision, writeback select and the handshake register
  ex_result ex_result_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .kind      (req.kind),
    .funct3    (req.funct3),
    .pc        (req.pc),
    .alu_result(alu_result),
    .flags     (flags),
    .link      (link),
    .target    (target),
    .resp      (resp),
    .resp_valid(resp_valid),
    .resp_ready(resp_ready)
  );

endmodule

//--- testbench/ex_stage_checker.sv
//////////////////////////////////////////////////
// execute stage assertions
// reset state, stall hold and the ready rule
//////////////////////////////////////////////////

`timescale 1ns/100ps

module ex_stage_checker
  import ex_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     req_ready,
  input ex_resp_t resp,
  input logic     resp_valid,
  input logic     resp_ready
);

  // number of failed assertions so far
  int unsigned fail_count = 0;

  // output register comes out of reset empty
  resp_empty_after_reset: assert property (@(posedge clk) !rst_n |=> !resp_valid)
    else begin
      $error("resp_valid high right after a reset cycle");
      fail_count++;
    end

  // a stalled response stays put until taken
  resp_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else begin
      $error("response changed or dropped while stalled");
      fail_count++;
    end

  // free slot or draining slot
  ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
      req_ready == (!resp_valid || resp_ready))
    else begin
      $error("req_ready does not follow resp_valid and resp_ready");
      fail_count++;
    end

endmodule

bind ex_stage ex_stage_checker checker_i (.*);

//--- testbench/ex_stage_tb.sv
//////////////////////////////////////////////////
// execute stage testbench
// file driven requests, random stalls, in-order check
//////////////////////////////////////////////////

`timescale 1ns/100ps

module ex_stage_tb
  import ex_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 5;
  localparam int CYCLES_PER_TEST = 40;

  logic     clk;
  logic     rst_n;
  ex_req_t  req;
  logic     req_valid;
  logic     req_ready;
  ex_resp_t resp;
  logic     resp_valid;
  logic     resp_ready;

  // test table from the data file
  string    test_name[$];
  ex_req_t  test_req[$];
  ex_resp_t test_exp[$];
  int       num_tests;
  bit       load_done;

  // indices of accepted requests, oldest first
  int          pending[$];
  int          num_resp;
  logic [31:0] lcg_state;

  ex_stage dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .resp      (resp),
    .resp_valid(resp_valid),
    .resp_ready(resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // numerical recipes lcg
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic compare_word(input string name, input string field,
                              input xlen_t exp, input xlen_t act);
    if (exp !== act)
      report_failure($sformatf("Mismatch %s %s: expected %h, actual %h",
                               name, field, exp, act));
  endtask

  task automatic compare_taken(input string name, input logic exp, input logic act);
    if (exp !== act)
      report_failure($sformatf("Mismatch %s taken: expected %b, actual %b",
                               name, exp, act));
  endtask

  task automatic check_response(input int idx);
    compare_word(test_name[idx], "pc", test_exp[idx].pc, resp.pc);
    compare_word(test_name[idx], "result", test_exp[idx].result, resp.result);
    compare_taken(test_name[idx], test_exp[idx].taken, resp.taken);
    compare_word(test_name[idx], "target", test_exp[idx].target, resp.target);
  endtask

  //////////////////////////////////////////////////
  // data file
  //////////////////////////////////////////////////

  // name kind funct3 alu_ctrl pc a b imm, then result taken target, all hex
  task automatic load_tests();
    int        fd;
    int        cnt;
    string     line;
    string     name;
    ex_kind_t  kind;
    funct3_t   funct3;
    alu_ctrl_t ctrl;
    xlen_t     pc;
    xlen_t     a;
    xlen_t     b;
    xlen_t     imm;
    xlen_t     result;
    logic      taken;
    xlen_t     target;
    ex_req_t   r;
    ex_resp_t  e;
    fd = $fopen("testbench/ex_stage_input.txt", "r");
    if (fd == 0)
      report_failure("cannot open testbench/ex_stage_input.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0)
        break;
      // skip blank and comment lines
      if (line.len() < 2 || line.substr(0, 0) == "#")
        continue;
      cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, kind, funct3,
                    ctrl, pc, a, b, imm, result, taken, target);
      if (cnt != 11)
        report_failure($sformatf("malformed line in input file: %s", line));
      r = '{kind: kind, funct3: funct3, alu_ctrl: ctrl, pc: pc, a: a, b: b, imm: imm};
      e = '{pc: pc, result: result, taken: taken, target: target};
      test_name.push_back(name);
      test_req.push_back(r);
      test_exp.push_back(e);
    end
    $fclose(fd);
    num_tests = test_req.size();
    if (num_tests == 0)
      report_failure("input file holds no tests");
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // handshake sampled at negedge, inputs change at posedge
  task automatic drive_requests();
    int idx;
    bit fire;
    idx = 0;
    forever begin
      @(negedge clk);
      fire = req_valid && req_ready;
      @(posedge clk);
      if (fire) begin
        pending.push_back(idx);
        idx++;
      end
      lcg_state = lcg_next(lcg_state);
      // roughly one stall in four
      resp_ready <= (lcg_state[29:28] != 2'b00);
      // hold req while it waits, else maybe insert a gap
      if (!req_valid || fire) begin
        if (idx < num_tests && lcg_state[31:30] != 2'b00) begin
          req       <= test_req[idx];
          req_valid <= 1'b1;
        end else begin
          req_valid <= 1'b0;
        end
      end
    end
  endtask

  initial begin
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b0;
    rst_n      = 1'b0;
    num_resp   = 0;
    load_done  = 1'b0;
    lcg_state  = 32'h0804_aee9;
    load_tests();
    load_done = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    drive_requests();
  end

  //////////////////////////////////////////////////
  // response monitor
  //////////////////////////////////////////////////

  initial begin
    int idx;
    bit accepted;
    accepted = 1'b0;
    wait (load_done && rst_n === 1'b1);
    while (num_resp < num_tests) begin
      @(negedge clk);
      if (dut_i.checker_i.fail_count != 0)
        report_failure("an assertion in the bound checker failed");
      // one cycle latency, last edge's request must sit in the register now
      if (accepted) begin
        if (!resp_valid)
          report_failure("no response one cycle after a request was accepted");
        check_response(pending[$]);
      end
      accepted = req_valid && req_ready;
      if (resp_valid && resp_ready) begin
        if (pending.size() == 0)
          report_failure("response arrived with no request outstanding");
        idx = pending.pop_front();
        check_response(idx);
        num_resp++;
      end
    end
    // no duplicate may follow the last response
    repeat (4) @(negedge clk);
    if (resp_valid || pending.size() != 0) begin
      report_failure("extra response after the last expected one");
    end else if (dut_i.checker_i.fail_count != 0) begin
      report_failure("an assertion in the bound checker failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

  // watchdog, scaled by the number of tests
  initial begin
    wait (load_done);
    repeat (RESET_CYCLES + num_tests * CYCLES_PER_TEST) @(posedge clk);
    report_failure($sformatf("watchdog: responses stopped arriving, %0d of %0d received",
                             num_resp, num_tests));
  end

endmodule

//--- testbench/ex_stage_input.txt
# name kind funct3 alu_ctrl pc a b imm | expected result taken target
# all fields hex; kind 0 alu, 1 branch, 2 jal, 3 jalr
add_basic   0 0 00 00000100 00000005 00000007 00000000 0000000c 0 00000100
add_wrap    0 0 00 00000104 ffffffff 00000001 00000000 00000000 0 00000104
sub_neg     0 0 08 00000108 00000003 00000010 00000000 fffffff3 0 00000108
xor_mix     0 0 04 0000010c f0f0f0f0 ff00ff00 00000000 0ff00ff0 0 0000010c
or_mix      0 0 06 00000110 f0f0f0f0 0f000f00 00000000 fff0fff0 0 00000110
and_mix     0 0 07 00000114 f0f0f0f0 ff00ff00 00000000 f000f000 0 00000114
lui_pass    0 0 0e 00000118 deadbeef 12345000 12345000 12345000 0 12345118
slt_ovf     0 0 0a 0000011c 80000000 00000001 00000000 00000001 0 0000011c
slt_pos_neg 0 0 0a 00000120 7fffffff ffffffff 00000000 00000000 0 00000120
sltu_big    0 0 0b 00000124 80000000 00000001 00000000 00000000 0 00000124
sltu_small  0 0 0b 00000128 00000001 ffffffff 00000000 00000001 0 00000128
sll_31      0 0 01 0000012c 00000001 0000001f 00000000 80000000 0 0000012c
sll_amt     0 0 01 00000130 12345678 00000024 00000000 23456780 0 00000130
srl_31      0 0 05 00000134 80000000 0000001f 00000000 00000001 0 00000134
srl_4       0 0 05 00000138 f0000000 00000004 00000000 0f000000 0 00000138
sra_31      0 0 0d 0000013c 80000000 0000001f 00000000 ffffffff 0 0000013c
sra_4       0 0 0d 00000140 f0000000 00000004 00000000 ff000000 0 00000140
beq_eq      1 0 08 00000200 00000005 00000005 00000040 00000000 1 00000240
beq_lt      1 0 08 00000204 00000003 00000005 00000040 fffffffe 0 00000244
beq_gt      1 0 08 00000208 00000005 00000003 00000040 00000002 0 00000248
bne_eq      1 1 08 0000020c 00000005 00000005 fffffff0 00000000 0 000001fc
bne_lt      1 1 08 00000210 00000003 00000005 fffffff0 fffffffe 1 00000200
bne_gt      1 1 08 00000214 00000007 00000005 fffffff0 00000002 1 00000204
blt_eq      1 4 08 00000218 ffffffff ffffffff 00000100 00000000 0 00000318
blt_ovf_lt  1 4 08 0000021c 80000000 00000001 00000100 7fffffff 1 0000031c
blt_ovf_gt  1 4 08 00000220 7fffffff ffffffff 00000100 80000000 0 00000320
bge_eq      1 5 08 00000224 00000005 00000005 00000008 00000000 1 0000022c
bge_ovf_lt  1 5 08 00000228 80000000 7fffffff 00000008 00000001 0 00000230
bge_ovf_gt  1 5 08 0000022c 7fffffff 80000000 00000008 ffffffff 1 00000234
bltu_eq     1 6 08 00000230 00000000 00000000 00000010 00000000 0 00000240
bltu_lt     1 6 08 00000234 00000001 ffffffff 00000010 00000002 1 00000244
bltu_gt     1 6 08 00000238 80000000 00000001 00000010 7fffffff 0 00000248
bgeu_eq     1 7 08 0000023c ffffffff ffffffff fffffffc 00000000 1 00000238
bgeu_lt     1 7 08 00000240 7fffffff 80000000 fffffffc ffffffff 0 0000023c
bgeu_gt     1 7 08 00000244 ffffffff 00000001 fffffffc fffffffe 1 00000240
jal_fwd     2 0 00 00000300 00000000 00000400 00000400 00000304 1 00000700
jal_back    2 0 00 00000304 00000000 fffffe00 fffffe00 00000308 1 00000104
jalr_odd    3 0 00 00000308 00001001 00000004 00000004 0000030c 1 00001004
jalr_neg    3 0 00 0000030c 00002000 ffffffff ffffffff 00000310 1 00001ffe

//--- files.f
+incdir+common
common/ex_pkg.sv
alu/shifter.sv
alu/alu.sv
hw/target_gen.sv
hw/ex_result.sv
hw/ex_stage.sv
testbench/ex_stage_checker.sv
testbench/ex_stage_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = ex_stage_tb
FILELIST  = files.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
